/* rtl/conv_pkg.sv */
package conv_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 5;
    localparam int DEPTH = 25;

    localparam int K_DIM = 3;
    localparam int F_DIM = 4;
    localparam int TAPS = K_DIM * K_DIM;
    localparam int N_WIN = 4;

    localparam int KERNEL_BASE = 0; // Kernel is stored column-major.
    localparam int FEATURE_BASE = 9; // Feature map is stored row-major.

    // Nine full-scale 8x8 products need four bits of growth.
    localparam int RES_W = 2 * DATA_W + $clog2(TAPS);

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [RES_W-1:0] value_t;
    typedef logic [$clog2(K_DIM)-1:0] idx_t;
    typedef logic [$clog2(N_WIN)-1:0] win_t;

    // Top-left corner of each 3x3 window inside the feature map.
    localparam logic [N_WIN-1:0][ADDR_W-1:0] WIN_BASE = {
        addr_t'(FEATURE_BASE + F_DIM + 1),
        addr_t'(FEATURE_BASE + F_DIM),
        addr_t'(FEATURE_BASE + 1),
        addr_t'(FEATURE_BASE)
    };

    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  valid;
        addr_t k_addr;
        addr_t f_addr;
        logic  first;
        logic  last;
        win_t  win;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        data_t k_val;
        data_t f_val;
        logic  first;
        logic  last;
        win_t  win;
    } operand_t;

    typedef struct packed {
        win_t   win;
        value_t value;
    } result_t;

endpackage

/* rtl/conv_sequencer.sv */
`timescale 1ns/1ps

module conv_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              busy,
    output conv_pkg::rd_req_t req
);

    conv_pkg::idx_t row;
    conv_pkg::idx_t col;
    conv_pkg::win_t win;

    logic last_col;
    logic last_row;
    logic last_win;
    logic last_term;

    conv_pkg::addr_t k_offset;
    conv_pkg::addr_t f_offset;

    assign last_col = (col == conv_pkg::idx_t'(conv_pkg::K_DIM - 1));
    assign last_row = (row == conv_pkg::idx_t'(conv_pkg::K_DIM - 1));
    assign last_win = (win == conv_pkg::win_t'(conv_pkg::N_WIN - 1));
    assign last_term = last_col && last_row && last_win;

    // Column-major kernel, row-major feature map.
    always_comb begin
        k_offset = conv_pkg::addr_t'(col) * conv_pkg::addr_t'(conv_pkg::K_DIM)
                 + conv_pkg::addr_t'(row);
        f_offset = conv_pkg::addr_t'(row) * conv_pkg::addr_t'(conv_pkg::F_DIM)
                 + conv_pkg::addr_t'(col);
    end

    // One request per busy cycle, formed straight from the counters.
    always_comb begin
        req.valid = busy;
        req.k_addr = conv_pkg::addr_t'(conv_pkg::KERNEL_BASE) + k_offset;
        req.f_addr = conv_pkg::WIN_BASE[win] + f_offset;
        req.first = (row == '0) && (col == '0);
        req.last = last_row && last_col;
        req.win = win;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            row <= '0;
            col <= '0;
            win <= '0;
        end else if (!busy) begin
            busy <= start; // The counters rest at zero while idle.
        end else begin
            if (last_col) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end

            if (last_col) begin
                if (last_row) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end

            // A window ends on its last row and column.
            if (last_col && last_row) begin
                if (last_win) begin
                    win <= '0;
                end else begin
                    win <= win + 1'b1;
                end
            end

            if (last_term) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* rtl/conv_buffer.sv */
`timescale 1ns/1ps

module conv_buffer (
    input  logic               clk,
    input  logic               rst,
    input  conv_pkg::mem_wr_t  wr,
    input  conv_pkg::rd_req_t  req,
    output conv_pkg::operand_t opnd
);

    // Kernel words first, then the feature map.
    conv_pkg::data_t mem [conv_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Both ports read in the same cycle, so a full term is fetched at once.
    always_ff @(posedge clk) begin
        if (!rst) begin
            opnd.valid <= 1'b0;
        end else begin
            opnd.valid <= req.valid;
        end

        opnd.k_val <= mem[req.k_addr];
        opnd.f_val <= mem[req.f_addr];
        opnd.first <= req.first; // Tags ride along with the data.
        opnd.last <= req.last;
        opnd.win <= req.win;
    end

endmodule

/* rtl/conv_mac.sv */
`timescale 1ns/1ps

module conv_mac (
    input  logic               clk,
    input  logic               rst,
    input  conv_pkg::operand_t opnd,
    output logic               res_valid,
    output conv_pkg::result_t  res
);

    logic [2*conv_pkg::DATA_W-1:0] product;
    conv_pkg::value_t acc;
    conv_pkg::value_t sum;

    assign product = opnd.k_val * opnd.f_val;

    // The first term of a window starts a fresh sum.
    always_comb begin
        if (opnd.first) begin
            sum = conv_pkg::value_t'(product);
        end else begin
            sum = acc + conv_pkg::value_t'(product);
        end
    end

    always_ff @(posedge clk) begin
        if (opnd.valid) begin
            acc <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= opnd.valid && opnd.last;
        end
    end

    // Result is held until the next window closes.
    always_ff @(posedge clk) begin
        if (opnd.valid && opnd.last) begin
            res.value <= sum;
            res.win <= opnd.win;
        end
    end

endmodule

/* rtl/conv_top.sv */
`timescale 1ns/1ps

module conv_top (
    input  logic               clk,
    input  logic               rst,
    input  conv_pkg::mem_wr_t  wr,
    input  logic               start,
    output logic               busy,
    output logic               res_valid,
    output conv_pkg::result_t  res
);

    conv_pkg::rd_req_t  req;
    conv_pkg::operand_t opnd;

    // Read addresses for the four windows.
    conv_sequencer u_sequencer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .req   (req)
    );

    conv_buffer u_buffer (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .req  (req),
        .opnd (opnd)
    );

    // One result per window, in window order.
    conv_mac u_mac (
        .clk       (clk),
        .rst       (rst),
        .opnd      (opnd),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

/* dv/conv_assert.sv */
`timescale 1ns/1ps

module conv_assert (
    input logic clk,
    input logic rst,
    input logic wr_valid,
    input logic start,
    input logic busy,
    input logic res_valid
);

    // The buffer must stay stable while a run reads it.
    property no_write_while_busy;
        @(posedge clk) disable iff (!rst)
            wr_valid |-> !busy;
    endproperty

    property res_valid_single;
        @(posedge clk) disable iff (!rst)
            res_valid |=> !res_valid;
    endproperty

    // 36 request cycles, then busy drops.
    property busy_length;
        @(posedge clk) disable iff (!rst)
            (start && !busy) |-> ##37 $fell(busy);
    endproperty

    assert property (no_write_while_busy)
        else $error("Buffer write seen while busy was high.");

    assert property (res_valid_single)
        else $error("res_valid was high in two consecutive cycles.");

    assert property (busy_length)
        else $error("busy did not fall 37 cycles after an accepted start.");

endmodule

bind conv_top conv_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .wr_valid  (wr.valid),
    .start     (start),
    .busy      (busy),
    .res_valid (res_valid)
);

/* dv/conv_checker.sv */
`timescale 1ns/1ps

module conv_checker (
    input  logic                                           clk,
    input  logic                                           rst,
    input  conv_pkg::mem_wr_t                              wr,
    input  logic                                           start,
    input  logic                                           busy,
    input  logic                                           res_valid,
    input  conv_pkg::result_t                              res,
    input  logic                                           exp_load,
    input  logic [conv_pkg::N_WIN-1:0][31:0]               exp_sums,
    input  logic [127:0]                                   test_name,
    output int                                             errors,
    output int                                             pending,
    output int                                             results
);

    int cycle = 0;
    int err_count = 0;
    int res_count = 0;
    int busy_len = 0;
    bit started = 1'b0;
    logic res_valid_q = 1'b0;

    logic [31:0] exp_value_q[$];
    int exp_win_q[$];
    int exp_time_q[$];
    logic [127:0] exp_name_q[$];

    assign errors = err_count;
    assign results = res_count;

    always @(posedge clk) begin
        logic [31:0] exp_value;
        int exp_win;
        int exp_time;
        logic [127:0] name;

        if (rst) begin
            cycle++;

            if (!started && (busy || res_valid)) begin
                $display("busy or res_valid went high before the first start.");
                err_count++;
            end
            if (wr.valid && busy) begin
                $display("A buffer write was issued while busy was high.");
                err_count++;
            end
            if (res_valid && res_valid_q) begin
                $display("res_valid stayed high for two cycles in a row.");
                err_count++;
            end

            if (busy) begin
                busy_len++;
            end else if (busy_len != 0) begin
                if (busy_len != 36) begin
                    $display("Error: busy_window: expected 36, actual %0d", busy_len);
                    err_count++;
                end
                busy_len = 0;
            end

            // An accepted start books four results at fixed offsets.
            if (start && !busy) begin
                started = 1'b1;
                for (int w = 0; w < conv_pkg::N_WIN; w++) begin
                    exp_win_q.push_back(w);
                    exp_time_q.push_back(cycle + 11 + 9 * w);
                    exp_value_q.push_back(exp_sums[w]);
                    exp_name_q.push_back(test_name);
                end
                if (!exp_load) begin
                    $display("A start was accepted without expected sums from the model.");
                    err_count++;
                end
            end else if (exp_load) begin
                $display("Expected sums were given but the start was not accepted.");
                err_count++;
            end

            if (res_valid) begin
                res_count++;
                if (exp_win_q.size() == 0) begin
                    $display("A result for window %0d arrived with no start pending.", res.win);
                    err_count++;
                end else begin
                    exp_value = exp_value_q.pop_front();
                    exp_win = exp_win_q.pop_front();
                    exp_time = exp_time_q.pop_front();
                    name = exp_name_q.pop_front();
                    if (32'(res.value) !== exp_value) begin
                        $display("Error: %s window %0d value: expected %0d, actual %0d",
                                 name, exp_win, exp_value, res.value);
                        err_count++;
                    end
                    if (int'(res.win) != exp_win) begin
                        $display("Error: %s window order: expected %0d, actual %0d",
                                 name, exp_win, res.win);
                        err_count++;
                    end
                    if (cycle != exp_time) begin
                        $display("Error: %s result cycle: expected %0d, actual %0d",
                                 name, exp_time, cycle);
                        err_count++;
                    end
                end
            end
            res_valid_q = res_valid;
        end
        pending = exp_win_q.size();
    end

endmodule

/* dv/tb_conv_top.sv */
`timescale 1ns/1ps

module tb_conv_top;

    localparam int N_RUNS = 10;
    localparam int RUN_CYCLES = 80;
    localparam int TIMEOUT_CYCLES = N_RUNS * RUN_CYCLES + 200;

    logic clk;
    logic rst;
    conv_pkg::mem_wr_t wr;
    logic start;
    logic busy;
    logic res_valid;
    conv_pkg::result_t res;

    logic exp_load;
    logic [conv_pkg::N_WIN-1:0][31:0] exp_sums;
    logic [127:0] test_tag;
    int chk_errors;
    int pending;
    int results;

    int tb_errors = 0;
    int starts = 0;
    conv_pkg::data_t model [conv_pkg::DEPTH]; // Mirror of every write.

    conv_top DUT (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .start     (start),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res)
    );

    conv_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .start     (start),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res),
        .exp_load  (exp_load),
        .exp_sums  (exp_sums),
        .test_name (test_tag),
        .errors    (chk_errors),
        .pending   (pending),
        .results   (results)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic int window_base(input int w);
        case (w)
            0: return 9;
            1: return 10;
            2: return 13;
            default: return 14;
        endcase
    endfunction

    // Kernel column-major from 0, feature map row-major from 9.
    function automatic int model_sum(input int w);
        int acc;
        int k_addr;
        int f_addr;
        acc = 0;
        for (int r = 0; r < conv_pkg::K_DIM; r++) begin
            for (int c = 0; c < conv_pkg::K_DIM; c++) begin
                k_addr = conv_pkg::KERNEL_BASE + c * conv_pkg::K_DIM + r;
                f_addr = window_base(w) + r * conv_pkg::F_DIM + c;
                acc += int'(model[k_addr]) * int'(model[f_addr]);
            end
        end
        return acc;
    endfunction

    // Moves to 1 ns after the next edge and drops all strobes.
    task automatic step_cycle();
        @(posedge clk);
        #1;
        wr.valid = 1'b0;
        start = 1'b0;
        exp_load = 1'b0;
    endtask

    task automatic wait_idle();
        step_cycle();
        while (busy) begin
            step_cycle();
        end
    endtask

    task automatic write_word(input int addr, input conv_pkg::data_t data);
        step_cycle();
        wr = '{valid: 1'b1, addr: conv_pkg::addr_t'(addr), data: data};
        model[addr] = data;
    endtask

    task automatic load_all(input bit all_ones);
        wait_idle();
        for (int a = 0; a < conv_pkg::DEPTH; a++) begin
            if (all_ones) begin
                write_word(a, 8'hFF);
            end else begin
                write_word(a, conv_pkg::data_t'($urandom));
            end
        end
    endtask

    task automatic load_some();
        wait_idle();
        for (int a = 0; a < conv_pkg::DEPTH; a++) begin
            if ($urandom % 3 == 0) begin
                write_word(a, conv_pkg::data_t'($urandom));
            end
        end
    endtask

    task automatic start_run(input logic [127:0] name);
        wait_idle();
        for (int w = 0; w < conv_pkg::N_WIN; w++) begin
            exp_sums[w] = model_sum(w);
        end
        test_tag = name;
        start = 1'b1;
        exp_load = 1'b1;
        starts++;
    endtask

    // A start while busy must be dropped by the sequencer.
    task automatic poke_start_while_busy(input int delay);
        repeat (delay) step_cycle();
        if (busy) begin
            start = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(5891));
        rst = 1'b0;
        wr = '0;
        start = 1'b0;
        exp_load = 1'b0;
        exp_sums = '0;
        test_tag = "reset";
        repeat (8) @(posedge clk);
        #1 rst = 1'b1;
        repeat (5) step_cycle();

        load_all(1'b0);
        start_run("rand_full");
        load_all(1'b1);
        start_run("all_ones");
        load_some();
        start_run("partial");
        load_all(1'b0);
        start_run("rand_pre_b2b");
        start_run("back_to_back");
        load_all(1'b0);
        start_run("busy_start");
        poke_start_while_busy(2 + $urandom % 10);
        poke_start_while_busy(2 + $urandom % 10);
        for (int i = 0; i < 4; i++) begin
            if ($urandom % 2 == 0) begin
                load_all(1'b0);
            end else begin
                load_some();
            end
            start_run("rand_mixed");
        end

        wait_idle();
        while (pending != 0) begin
            step_cycle();
        end
        repeat (20) step_cycle(); // Catch any stray result.

        if (results != starts * conv_pkg::N_WIN) begin
            $display("Error: result_count: expected %0d, actual %0d",
                     starts * conv_pkg::N_WIN, results);
            tb_errors++;
        end

        $display("Done: %0d runs, %0d results, %0d errors", starts, results,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

/* vlog.f */
rtl/conv_pkg.sv
rtl/conv_sequencer.sv
rtl/conv_buffer.sv
rtl/conv_mac.sv
rtl/conv_top.sv
dv/conv_assert.sv
dv/conv_checker.sv
dv/tb_conv_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the convolution testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_top \
    -f vlog.f -o sim_conv \
    && ./obj_dir/sim_conv +verilator+error+limit+100 | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
